// ==== address_sequencer.sv ====
// ----------------------------------------
// per-thread pointer sequencer. a slot starts when its thread is next,
// its address leaves the pipeline three cycles later.
// ----------------------------------------
`timescale 1ns/100ps

module address_sequencer import thread_pkg::*; #(
    parameter int THREAD_COUNT      = 8,
    parameter int THREAD_ADDR_WIDTH = 3,
    parameter int WORD_WIDTH        = 16,
    parameter int INITIAL_THREAD    = 0
) (
    input  logic                         clock,
    input  logic                         arst_n,
    input  logic                         run,
    input  logic                         restart,
    input  logic [WORD_WIDTH-1:0]        limit,
    input  logic [WORD_WIDTH-1:0]        read_data,
    output value_entry_e                 read_entry,
    output logic                         addr_valid,
    output logic [THREAD_ADDR_WIDTH-1:0] addr_thread,
    output logic [WORD_WIDTH-1:0]        addr_data
);

    logic [THREAD_ADDR_WIDTH-1:0] next_thread;
    logic [THREAD_COUNT-1:0]      reload_flag;
    logic [WORD_WIDTH-1:0]        pointer [THREAD_COUNT];
    slot_op_e                     slot_op;
    slot_op_e                     s1_op;
    slot_op_e                     s2_op;
    logic [THREAD_ADDR_WIDTH-1:0] s1_thread;
    logic [THREAD_ADDR_WIDTH-1:0] s2_thread;
    logic [WORD_WIDTH-1:0]        step_sum;
    logic                         step_fits;

    thread_number #(
        .THREAD_COUNT      (THREAD_COUNT),
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH),
        .INITIAL_THREAD    (INITIAL_THREAD)
    ) thread_number_inst (
        .clock          (clock),
        .arst_n         (arst_n),
        .current_thread (),
        .next_thread    (next_thread)
    );

    // ---- slot start ------------------------
    always_comb begin
        if (!run) begin
            slot_op = op_idle;
        end else if (reload_flag[next_thread]) begin
            slot_op = op_reload;
        end else begin
            slot_op = op_step;
        end
    end

    assign read_entry = reload_flag[next_thread] ? entry_offset : entry_increment;

    // stage 1 covers the memory latency.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            s1_op <= op_idle;
            s2_op <= op_idle;
        end else begin
            s1_op <= slot_op;
            s2_op <= s1_op;
        end
    end

    always_ff @(posedge clock) begin
        s1_thread <= next_thread;
        s2_thread <= s1_thread;
    end

    // ---- stage 2, read_data valid ----------
    assign step_sum  = pointer[s2_thread] + read_data;
    assign step_fits = (step_sum < limit);

    always_ff @(posedge clock) begin
        if (s2_op == op_reload) begin
            pointer[s2_thread] <= read_data;
        end else if ((s2_op == op_step) && step_fits) begin
            pointer[s2_thread] <= step_sum;
        end
    end

    // restart overrides a reload finishing in the same cycle.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            reload_flag <= '1;
        end else if (restart) begin
            reload_flag <= '1;
        end else if (s2_op == op_reload) begin
            reload_flag[s2_thread] <= 1'b0;
        end else if ((s2_op == op_step) && !step_fits) begin
            reload_flag[s2_thread] <= 1'b1;
        end
    end

    // ---- output ----------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            addr_valid <= 1'b0;
        end else begin
            addr_valid <= (s2_op == op_reload) || ((s2_op == op_step) && step_fits);
        end
    end

    always_ff @(posedge clock) begin
        addr_thread <= s2_thread;
        addr_data   <= (s2_op == op_reload) ? read_data : step_sum;
    end

endmodule

// ==== csr_pkg.sv ====
// ----------------------------------------
// register map, AXI response codes and write states
// of the control and status block.
// ----------------------------------------
package csr_pkg;

    localparam int CSR_ADDR_WIDTH = 8;
    localparam int CSR_DATA_WIDTH = 32;

    // ---- register map ----------------------
    // bit 0 run, bit 1 restart (self clearing).
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_CTRL       = 8'h00;
    // wrap limit in the low word bits.
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_LIMIT      = 8'h04;
    // thread t, entry e at base + 8t + 4e. write only.
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_VALUE_BASE = 8'h40;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_e;

    typedef enum logic [1:0] {
        st_idle      = 2'd0,
        st_wait_slot = 2'd1,
        st_resp      = 2'd2
    } csr_state_e;

endpackage

// ==== engine_assert.sv ====
// ----------------------------------------
// concurrent checks on the bus responses and the address output,
// bound into the engine top level.
// ----------------------------------------
`timescale 1ns/100ps

module engine_assert #(
    parameter int THREAD_COUNT      = 8,
    parameter int THREAD_ADDR_WIDTH = 3
) (
    input logic                         clock,
    input logic                         arst_n,
    input logic                         s_axi_bvalid,
    input logic                         s_axi_bready,
    input logic [1:0]                   s_axi_bresp,
    input logic                         s_axi_rvalid,
    input logic                         s_axi_rready,
    input logic [1:0]                   s_axi_rresp,
    input logic [31:0]                  s_axi_rdata,
    input logic                         addr_valid,
    input logic [THREAD_ADDR_WIDTH-1:0] addr_thread
);

    // responses wait, unchanged, for the master.
    assert property (@(posedge clock) disable iff (!arst_n)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
        else $error("write response dropped before bready");

    assert property (@(posedge clock) disable iff (!arst_n)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rresp)
        && $stable(s_axi_rdata))
        else $error("read response dropped before rready");

    assert property (@(posedge clock) disable iff (!arst_n)
        addr_valid |-> (32'(addr_thread) < THREAD_COUNT))
        else $error("addr_thread out of range");

    assert property (@(posedge clock) disable iff (!arst_n) !$isunknown(addr_valid))
        else $error("addr_valid unknown");

endmodule

bind thread_address_engine engine_assert #(
    .THREAD_COUNT      (THREAD_COUNT),
    .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH)
) engine_assert_inst (
    .clock        (clock),
    .arst_n       (arst_n),
    .s_axi_bvalid (s_axi_bvalid),
    .s_axi_bready (s_axi_bready),
    .s_axi_bresp  (s_axi_bresp),
    .s_axi_rvalid (s_axi_rvalid),
    .s_axi_rready (s_axi_rready),
    .s_axi_rresp  (s_axi_rresp),
    .s_axi_rdata  (s_axi_rdata),
    .addr_valid   (addr_valid),
    .addr_thread  (addr_thread)
);

// ==== ram_sdp.sv ====
// ----------------------------------------
// simple dual-port memory, one write port and one registered read port.
// ----------------------------------------
`timescale 1ns/100ps

module ram_sdp #(
    parameter int WORD_WIDTH = 16,
    parameter int ADDR_WIDTH = 4,
    parameter int DEPTH      = 16
) (
    input  logic                  clock,
    input  logic                  wren,
    input  logic [ADDR_WIDTH-1:0] write_addr,
    input  logic [WORD_WIDTH-1:0] write_data,
    input  logic [ADDR_WIDTH-1:0] read_addr,
    output logic [WORD_WIDTH-1:0] read_data
);

    logic [WORD_WIDTH-1:0] mem [DEPTH];

    // same-address read during a write returns the old word.
    always_ff @(posedge clock) begin
        if (wren) begin
            mem[write_addr] <= write_data;
        end
        read_data <= mem[read_addr];
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
    --top-module tb_thread_address_engine -o sim_engine
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_engine > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression passed" sim.log; then
    exit 0
fi
exit 1

// ==== tb_thread_address_engine.sv ====
// ----------------------------------------
// testbench for the thread address engine. drives the AXI4-Lite bus,
// models each thread's pointer and checks the address stream.
// ----------------------------------------
`timescale 1ns/100ps

module tb_thread_address_engine import csr_pkg::*;;

    localparam int THREADS = 8;
    localparam int MAX_CYCLES = 20000;

    logic clock;
    logic arst_n;
    logic [7:0] s_axi_awaddr;
    logic [7:0] s_axi_araddr;
    logic [31:0] s_axi_wdata;
    logic [31:0] s_axi_rdata;
    logic s_axi_awvalid;
    logic s_axi_awready;
    logic s_axi_wvalid;
    logic s_axi_wready;
    logic [1:0] s_axi_bresp;
    logic [1:0] s_axi_rresp;
    logic s_axi_bvalid;
    logic s_axi_bready;
    logic s_axi_arvalid;
    logic s_axi_arready;
    logic s_axi_rvalid;
    logic s_axi_rready;
    logic addr_valid;
    logic [2:0] addr_thread;
    logic [15:0] addr_data;

    // reference model, one set of values per thread.
    logic [15:0] m_inc [THREADS];
    logic [15:0] m_off [THREADS];
    logic [15:0] m_ptr [THREADS];
    bit          m_flag [THREADS];
    int          m_count [THREADS];
    logic [15:0] m_limit;
    int          out_thread;
    bit          model_on;
    bit          quiet;
    int          errors;
    int          cycles;
    int          test_errors;
    int          tests_done;
    int          tests_failed;

    thread_address_engine thread_address_engine_inst (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // ---- checks ----------------------------
    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic end_test(input string name);
        tests_done++;
        if (errors != test_errors) begin
            tests_failed++;
        end
        $display("test %0d %s: %0d errors", tests_done, name, errors - test_errors);
        test_errors = errors;
    endtask

    // ---- bus tasks -------------------------
    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data,
                             input bit hold, output logic [1:0] resp);
        int delay;
        delay = hold ? int'($urandom % 4) : 0;
        @(posedge clock);
        s_axi_awaddr  <= addr;
        s_axi_wdata   <= data;
        s_axi_awvalid <= 1'b1;
        s_axi_wvalid  <= 1'b1;
        do @(posedge clock); while (!s_axi_awready);
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid  <= 1'b0;
        while (!s_axi_bvalid) @(posedge clock);
        repeat (delay) @(posedge clock);
        s_axi_bready <= 1'b1;
        @(posedge clock);
        resp = s_axi_bresp;
        s_axi_bready <= 1'b0;
    endtask

    task automatic bus_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int delay;
        delay = int'($urandom % 4);
        @(posedge clock);
        s_axi_araddr  <= addr;
        s_axi_arvalid <= 1'b1;
        do @(posedge clock); while (!s_axi_arready);
        s_axi_arvalid <= 1'b0;
        while (!s_axi_rvalid) @(posedge clock);
        repeat (delay) @(posedge clock);
        s_axi_rready <= 1'b1;
        @(posedge clock);
        data = s_axi_rdata;
        resp = s_axi_rresp;
        s_axi_rready <= 1'b0;
    endtask

    // writes one value word and checks its response.
    task automatic load_value(input int t, input int e, input logic [15:0] v, input bit hold);
        logic [1:0] resp;
        bus_write(CSR_VALUE_BASE + 8'(8 * t + 4 * e), {16'h0, v}, hold, resp);
        compare("bresp", resp_okay, resp);
    endtask

    task automatic write_ctrl(input logic [31:0] data);
        logic [1:0] resp;
        bus_write(CSR_CTRL, data, 1'b1, resp);
        compare("bresp", resp_okay, resp);
    endtask

    // ---- monitor ---------------------------
    // a wrap leaves no output, so a failed step means the offset comes next.
    always @(posedge clock) begin
        logic [15:0] sum;
        logic [15:0] exp_data;
        if (arst_n && addr_valid && quiet) begin
            errors++;
            $display("addr_valid seen at %0t while the generator should be stopped", $time);
        end else if (arst_n && addr_valid && model_on) begin
            sum = m_ptr[addr_thread] + m_inc[addr_thread];
            if (m_flag[addr_thread] || !(sum < m_limit)) begin
                exp_data = m_off[addr_thread];
            end else begin
                exp_data = sum;
            end
            m_ptr[addr_thread]  = exp_data;
            m_flag[addr_thread] = 1'b0;
            m_count[addr_thread]++;
            compare("addr_data", {16'h0, exp_data}, {16'h0, addr_data});
        end
    end

    // an address leaves the pipeline two threads behind the current one.
    always @(posedge clock) begin
        if (!arst_n) begin
            out_thread = THREADS - 2;
        end else begin
            if (addr_valid) begin
                compare("addr_thread", out_thread, addr_thread);
            end
            out_thread = (out_thread + 1) % THREADS;
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // ---- tests -----------------------------
    initial begin
        logic [31:0] rdata;
        logic [31:0] wdata;
        logic [1:0]  resp;
        int t;
        void'($urandom(42367));
        {s_axi_awaddr, s_axi_araddr, s_axi_wdata} = '0;
        {s_axi_awvalid, s_axi_wvalid, s_axi_bready, s_axi_arvalid, s_axi_rready} = '0;
        {model_on, quiet, errors, cycles, test_errors, tests_done, tests_failed} = '0;
        arst_n = 1'b0;
        repeat (2) @(posedge clock);
        arst_n <= 1'b1;

        // 1: reset values.
        @(posedge clock);
        compare("addr_valid", 0, addr_valid);
        compare("bvalid", 0, s_axi_bvalid);
        compare("rvalid", 0, s_axi_rvalid);
        bus_read(CSR_CTRL, rdata, resp);
        compare("ctrl", 0, rdata);
        bus_read(CSR_LIMIT, rdata, resp);
        compare("limit", 32'h0000_ffff, rdata);
        end_test("reset");

        // 2: register readback and error responses.
        for (int i = 0; i < 6; i++) begin
            wdata = $urandom;
            bus_write(CSR_CTRL, wdata, 1'b1, resp);
            bus_read(CSR_CTRL, rdata, resp);
            compare("ctrl", {31'h0, wdata[0]}, rdata);
            wdata = $urandom;
            bus_write(CSR_LIMIT, wdata, 1'b1, resp);
            bus_read(CSR_LIMIT, rdata, resp);
            compare("limit", {16'h0, wdata[15:0]}, rdata);
        end
        bus_write(8'h08, 32'h1234, 1'b1, resp);
        compare("bresp", resp_slverr, resp);
        bus_read(8'h0c, rdata, resp);
        compare("rresp", resp_slverr, resp);
        bus_read(CSR_VALUE_BASE, rdata, resp);
        compare("rresp", resp_slverr, resp);
        // stop, let the pipeline drain, then clear every thread.
        write_ctrl(32'h0);
        repeat (10) @(posedge clock);
        write_ctrl(32'h2);
        repeat (10) @(posedge clock);
        end_test("registers");

        // 3: value writes with run low.
        quiet = 1'b1;
        for (int i = 0; i < 2 * THREADS; i++) begin
            m_inc[i / 2] = 16'(1 + $urandom % 255);
            m_off[i / 2] = 16'($urandom % 1024);
            m_flag[i / 2] = 1'b1;
        end
        for (int i = 0; i < 6; i++) begin
            t = int'($urandom % THREADS);
            load_value(t, i % 2, (i % 2) ? m_off[t] : m_inc[t], 1'b1);
        end
        repeat (20) @(posedge clock);
        quiet = 1'b0;
        end_test("value writes");

        // 4: run with random values and limit.
        for (int i = 0; i < THREADS; i++) begin
            load_value(i, 0, m_inc[i], 1'b1);
            load_value(i, 1, m_off[i], 1'b1);
            m_count[i] = 0;
        end
        m_limit = 16'(16'h0800 + $urandom % 16'h1000);
        bus_write(CSR_LIMIT, {16'h0, m_limit}, 1'b1, resp);
        model_on = 1'b1;
        write_ctrl(32'h1);
        repeat (400) @(posedge clock);
        for (int i = 0; i < THREADS; i++) begin
            if (m_count[i] < 10) begin
                errors++;
                $display("thread %0d produced only %0d addresses", i, m_count[i]);
            end
        end
        end_test("run");

        // 5: stop, restart and run again.
        write_ctrl(32'h0);
        repeat (4) @(posedge clock);
        quiet = 1'b1;
        repeat (20) @(posedge clock);
        quiet = 1'b0;
        write_ctrl(32'h2);
        @(negedge clock);
        for (int i = 0; i < THREADS; i++) begin
            m_flag[i] = 1'b1;
            m_count[i] = 0;
        end
        write_ctrl(32'h1);
        repeat (200) @(posedge clock);
        for (int i = 0; i < THREADS; i++) begin
            if (m_count[i] == 0) begin
                errors++;
                $display("thread %0d did not start again after restart", i);
            end
        end
        end_test("restart");

        // 6: change one increment while running.
        t = int'($urandom % THREADS);
        wdata = 32'(1 + $urandom % 255);
        load_value(t, 0, wdata[15:0], 1'b0);
        // the slot already in flight still uses the old increment.
        repeat (4) @(posedge clock);
        @(negedge clock);
        m_inc[t] = wdata[15:0];
        repeat (300) @(posedge clock);
        write_ctrl(32'h0);
        repeat (10) @(posedge clock);
        end_test("live update");

        $display("%0d tests, %0d failed, %0d errors", tests_done, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== thread_address_engine.sv ====
// ----------------------------------------
// top level, register block, value memory and sequencer wired together.
// ----------------------------------------
`timescale 1ns/100ps

module thread_address_engine import csr_pkg::*, thread_pkg::*; #(
    parameter int THREAD_COUNT      = 8,
    parameter int THREAD_ADDR_WIDTH = 3,
    parameter int WORD_WIDTH        = 16,
    parameter int INITIAL_THREAD    = 0
) (
    input  logic                         clock,
    input  logic                         arst_n,
    input  logic [CSR_ADDR_WIDTH-1:0]    s_axi_awaddr,
    input  logic                         s_axi_awvalid,
    output logic                         s_axi_awready,
    input  logic [CSR_DATA_WIDTH-1:0]    s_axi_wdata,
    input  logic                         s_axi_wvalid,
    output logic                         s_axi_wready,
    output logic [1:0]                   s_axi_bresp,
    output logic                         s_axi_bvalid,
    input  logic                         s_axi_bready,
    input  logic [CSR_ADDR_WIDTH-1:0]    s_axi_araddr,
    input  logic                         s_axi_arvalid,
    output logic                         s_axi_arready,
    output logic [CSR_DATA_WIDTH-1:0]    s_axi_rdata,
    output logic [1:0]                   s_axi_rresp,
    output logic                         s_axi_rvalid,
    input  logic                         s_axi_rready,
    output logic                         addr_valid,
    output logic [THREAD_ADDR_WIDTH-1:0] addr_thread,
    output logic [WORD_WIDTH-1:0]        addr_data
);

    logic                  wren;
    value_entry_e          write_entry;
    logic [WORD_WIDTH-1:0] write_data;
    logic                  run;
    logic                  restart;
    logic [WORD_WIDTH-1:0] limit;
    value_entry_e          read_entry;
    logic [WORD_WIDTH-1:0] read_data;

    value_csr #(
        .THREAD_COUNT      (THREAD_COUNT),
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH),
        .WORD_WIDTH        (WORD_WIDTH),
        .INITIAL_THREAD    (INITIAL_THREAD)
    ) value_csr_inst (
        .clock         (clock),
        .arst_n        (arst_n),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .wren          (wren),
        .write_entry   (write_entry),
        .write_data    (write_data),
        .run           (run),
        .restart       (restart),
        .limit         (limit)
    );

    // same thread parameters everywhere keep the counters in lockstep.
    thread_value #(
        .THREAD_COUNT      (THREAD_COUNT),
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH),
        .WORD_WIDTH        (WORD_WIDTH),
        .INITIAL_THREAD    (INITIAL_THREAD)
    ) thread_value_inst (
        .clock       (clock),
        .arst_n      (arst_n),
        .wren        (wren),
        .write_entry (write_entry),
        .write_data  (write_data),
        .read_entry  (read_entry),
        .read_data   (read_data)
    );

    address_sequencer #(
        .THREAD_COUNT      (THREAD_COUNT),
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH),
        .WORD_WIDTH        (WORD_WIDTH),
        .INITIAL_THREAD    (INITIAL_THREAD)
    ) address_sequencer_inst (
        .clock       (clock),
        .arst_n      (arst_n),
        .run         (run),
        .restart     (restart),
        .limit       (limit),
        .read_data   (read_data),
        .read_entry  (read_entry),
        .addr_valid  (addr_valid),
        .addr_thread (addr_thread),
        .addr_data   (addr_data)
    );

endmodule

// ==== thread_number.sv ====
// ----------------------------------------
// round-robin thread counter, current and next thread.
// ----------------------------------------
`timescale 1ns/100ps

module thread_number #(
    parameter int THREAD_COUNT      = 8,
    parameter int THREAD_ADDR_WIDTH = 3,
    parameter int INITIAL_THREAD    = 0
) (
    input  logic                         clock,
    input  logic                         arst_n,
    output logic [THREAD_ADDR_WIDTH-1:0] current_thread,
    output logic [THREAD_ADDR_WIDTH-1:0] next_thread
);

    localparam logic [THREAD_ADDR_WIDTH-1:0] LAST_THREAD =
        THREAD_ADDR_WIDTH'(THREAD_COUNT - 1);
    localparam logic [THREAD_ADDR_WIDTH-1:0] FIRST_NEXT =
        THREAD_ADDR_WIDTH'((INITIAL_THREAD + 1) % THREAD_COUNT);

    // next_thread runs one step ahead, so current just follows it.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            current_thread <= THREAD_ADDR_WIDTH'(INITIAL_THREAD);
            next_thread    <= FIRST_NEXT;
        end else begin
            current_thread <= next_thread;
            if (next_thread == LAST_THREAD) begin
                next_thread <= '0;
            end else begin
                next_thread <= next_thread + 1'b1;
            end
        end
    end

endmodule

// ==== thread_pkg.sv ====
// ----------------------------------------
// datapath types shared by the value memory, the sequencer
// and the register block.
// ----------------------------------------
package thread_pkg;

    // the two words kept in each thread's bank.
    typedef enum logic {
        entry_increment = 1'b0,
        entry_offset    = 1'b1
    } value_entry_e;

    // what a thread's slot does as it moves down the pipeline.
    typedef enum logic [1:0] {
        op_idle   = 2'd0,
        op_step   = 2'd1,
        op_reload = 2'd2
    } slot_op_e;

endpackage

// ==== thread_value.sv ====
// ----------------------------------------
// per-thread value memory. writes go to the current thread's bank,
// reads to the next thread's bank, two cycles of read latency.
// ----------------------------------------
`timescale 1ns/100ps

module thread_value import thread_pkg::*; #(
    parameter int THREAD_COUNT      = 8,
    parameter int THREAD_ADDR_WIDTH = 3,
    parameter int WORD_WIDTH        = 16,
    parameter int INITIAL_THREAD    = 0
) (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  wren,
    input  value_entry_e          write_entry,
    input  logic [WORD_WIDTH-1:0] write_data,
    input  value_entry_e          read_entry,
    output logic [WORD_WIDTH-1:0] read_data
);

    // two words per thread.
    localparam int RAM_DEPTH      = THREAD_COUNT * 2;
    localparam int RAM_ADDR_WIDTH = THREAD_ADDR_WIDTH + 1;

    logic [THREAD_ADDR_WIDTH-1:0] current_thread;
    logic [THREAD_ADDR_WIDTH-1:0] next_thread;
    logic [RAM_ADDR_WIDTH-1:0]    write_addr;
    logic [RAM_ADDR_WIDTH-1:0]    read_addr;
    logic [WORD_WIDTH-1:0]        ram_data;

    thread_number #(
        .THREAD_COUNT      (THREAD_COUNT),
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH),
        .INITIAL_THREAD    (INITIAL_THREAD)
    ) thread_number_inst (
        .clock          (clock),
        .arst_n         (arst_n),
        .current_thread (current_thread),
        .next_thread    (next_thread)
    );

    // thread picks the bank, entry the word in it.
    assign write_addr = {current_thread, write_entry};
    assign read_addr  = {next_thread, read_entry};

    ram_sdp #(
        .WORD_WIDTH (WORD_WIDTH),
        .ADDR_WIDTH (RAM_ADDR_WIDTH),
        .DEPTH      (RAM_DEPTH)
    ) ram_sdp_inst (
        .clock      (clock),
        .wren       (wren),
        .write_addr (write_addr),
        .write_data (write_data),
        .read_addr  (read_addr),
        .read_data  (ram_data)
    );

    // extra stage after the memory, retimed into the block ram.
    always_ff @(posedge clock) begin
        read_data <= ram_data;
    end

endmodule

// ==== value_csr.sv ====
// ----------------------------------------
// AXI4-Lite register block. holds run, restart and limit, and
// delays each value write until its thread's slot comes round.
// ----------------------------------------
`timescale 1ns/100ps

module value_csr import csr_pkg::*, thread_pkg::*; #(
    parameter int THREAD_COUNT      = 8,
    parameter int THREAD_ADDR_WIDTH = 3,
    parameter int WORD_WIDTH        = 16,
    parameter int INITIAL_THREAD    = 0
) (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic [CSR_ADDR_WIDTH-1:0] s_axi_awaddr,
    input  logic                      s_axi_awvalid,
    output logic                      s_axi_awready,
    input  logic [CSR_DATA_WIDTH-1:0] s_axi_wdata,
    input  logic                      s_axi_wvalid,
    output logic                      s_axi_wready,
    output axi_resp_e                 s_axi_bresp,
    output logic                      s_axi_bvalid,
    input  logic                      s_axi_bready,
    input  logic [CSR_ADDR_WIDTH-1:0] s_axi_araddr,
    input  logic                      s_axi_arvalid,
    output logic                      s_axi_arready,
    output logic [CSR_DATA_WIDTH-1:0] s_axi_rdata,
    output axi_resp_e                 s_axi_rresp,
    output logic                      s_axi_rvalid,
    input  logic                      s_axi_rready,
    output logic                      wren,
    output value_entry_e              write_entry,
    output logic [WORD_WIDTH-1:0]     write_data,
    output logic                      run,
    output logic                      restart,
    output logic [WORD_WIDTH-1:0]     limit
);

    // 8 bytes per thread in the value window.
    localparam logic [CSR_ADDR_WIDTH-1:0] WINDOW_SIZE = CSR_ADDR_WIDTH'(8 * THREAD_COUNT);

    csr_state_e                   state;
    logic [THREAD_ADDR_WIDTH-1:0] current_thread;
    logic [THREAD_ADDR_WIDTH-1:0] target_thread;
    logic [CSR_ADDR_WIDTH-1:0]    aw_offset;
    logic                         aw_in_window;
    logic                         write_take;
    logic                         read_take;

    thread_number #(
        .THREAD_COUNT      (THREAD_COUNT),
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH),
        .INITIAL_THREAD    (INITIAL_THREAD)
    ) thread_number_inst (
        .clock          (clock),
        .arst_n         (arst_n),
        .current_thread (current_thread),
        .next_thread    ()
    );

    // ---- accept ----------------------------
    // one transaction at a time, writes first.
    assign write_take = (state == st_idle) && !s_axi_rvalid
                        && s_axi_awvalid && s_axi_wvalid;
    assign read_take  = (state == st_idle) && !s_axi_rvalid && s_axi_arvalid
                        && !(s_axi_awvalid && s_axi_wvalid);

    assign s_axi_awready = write_take;
    assign s_axi_wready  = write_take;
    assign s_axi_arready = read_take;
    assign s_axi_bvalid  = (state == st_resp);

    assign aw_offset    = s_axi_awaddr - CSR_VALUE_BASE;
    assign aw_in_window = (s_axi_awaddr >= CSR_VALUE_BASE) && (aw_offset < WINDOW_SIZE)
                          && (aw_offset[1:0] == 2'b00);

    // memory write fires in the target thread's own slot.
    assign wren = (state == st_wait_slot) && (current_thread == target_thread);

    // ---- write channel ---------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state       <= st_idle;
            s_axi_bresp <= resp_okay;
            run         <= 1'b0;
            restart     <= 1'b0;
            limit       <= '1;
        end else begin
            restart <= 1'b0;
            case (state)
                st_idle: begin
                    if (write_take) begin
                        s_axi_bresp <= resp_okay;
                        state       <= st_resp;
                        if (s_axi_awaddr == CSR_CTRL) begin
                            run     <= s_axi_wdata[0];
                            restart <= s_axi_wdata[1];
                        end else if (s_axi_awaddr == CSR_LIMIT) begin
                            limit <= s_axi_wdata[WORD_WIDTH-1:0];
                        end else if (aw_in_window) begin
                            state <= st_wait_slot;
                        end else begin
                            s_axi_bresp <= resp_slverr;
                        end
                    end
                end
                st_wait_slot: begin
                    if (wren) begin
                        state <= st_resp;
                    end
                end
                st_resp: begin
                    if (s_axi_bready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // value write held here while waiting for the slot.
    always_ff @(posedge clock) begin
        if (write_take) begin
            target_thread <= aw_offset[THREAD_ADDR_WIDTH+2:3];
            write_entry   <= value_entry_e'(aw_offset[2]);
            write_data    <= s_axi_wdata[WORD_WIDTH-1:0];
        end
    end

    // ---- read channel ----------------------
    // the value window is write only.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            s_axi_rvalid <= 1'b0;
            s_axi_rresp  <= resp_okay;
            s_axi_rdata  <= '0;
        end else if (read_take) begin
            s_axi_rvalid <= 1'b1;
            s_axi_rresp  <= resp_okay;
            case (s_axi_araddr)
                CSR_CTRL:  s_axi_rdata <= CSR_DATA_WIDTH'(run);
                CSR_LIMIT: s_axi_rdata <= CSR_DATA_WIDTH'(limit);
                default: begin
                    s_axi_rdata <= '0;
                    s_axi_rresp <= resp_slverr;
                end
            endcase
        end else if (s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
        end
    end

endmodule

// ==== verilog.f ====
thread_pkg.sv
csr_pkg.sv
ram_sdp.sv
thread_number.sv
thread_value.sv
value_csr.sv
address_sequencer.sv
thread_address_engine.sv
engine_assert.sv
tb_thread_address_engine.sv
